/* Makefile */
VERILATOR  ?= verilator
TOP        ?= cortex_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
SRCS       := $(wildcard source/*.sv sim/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || { echo "Simulation ended early, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
source/cortex_lb_pkg.sv
source/cortex_audio_pkg.sv
source/lb_splitter.sv
source/rst_cntrl.sv
source/pcm_buffer.sv
source/pcm_energy.sv
source/sys_mem_intf.sv
source/cortex.sv
sim/cortex_props.sv
sim/cortex_tb.sv

/* sim/cortex_props.sv */
module cortex_props (
  input logic                                        clk,
  input logic                                        rst_n,
  input logic                                        lb_wr_en,
  input logic                                        lb_rd_en,
  input logic                                        lb_wr_valid,
  input logic                                        lb_rd_valid,
  input logic                                        agent_wren,
  input logic                                        agent_wait,
  input logic                                        sys_mem_wait,
  input logic                                        sys_mem_wren,
  input logic [cortex_audio_pkg::SYS_MEM_ADDR_W-1:0] sys_mem_addr,
  input logic [cortex_audio_pkg::SYS_MEM_DATA_W-1:0] sys_mem_wdata
);
  timeunit 1ns;
  timeprecision 100ps;

  // Count of failed assertions
  int assert_fails = 0;

  // Memory payload frozen while memory stalls
  mem_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (sys_mem_wren && sys_mem_wait) |=>
      (sys_mem_wren && $stable(sys_mem_addr) && $stable(sys_mem_wdata)))
    else begin
      $error("sys_mem outputs changed while sys_mem_wait was high");
      assert_fails++;
    end

  // Agent request held until taken
  agent_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (agent_wren && agent_wait) |=> agent_wren)
    else begin
      $error("agent_wren dropped while agent_wait was high");
      assert_fails++;
    end

  // Answers only follow a strobe
  wr_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
    lb_wr_valid |-> $past(lb_wr_en))
    else begin
      $error("lb_wr_valid without a write strobe one cycle earlier");
      assert_fails++;
    end
  rd_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
    lb_rd_valid |-> $past(lb_rd_en))
    else begin
      $error("lb_rd_valid without a read strobe one cycle earlier");
      assert_fails++;
    end

endmodule

bind cortex cortex_props props_inst (.*);

/* sim/cortex_tb.sv */
module cortex_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS = 11;
  localparam int RST_CYCLES = 10;
  // Budget of 200 cycles per table row
  localparam int MAX_CYCLES = RST_CYCLES + 200 * NUM_TESTS;
  localparam logic [31:0] MEM_BASE = 32'h0000_1200;
  // Row kinds
  localparam int K_WR_RD = 0;
  localparam int K_RD = 1;
  localparam int K_FRAME = 2;
  localparam int K_FRAME_BP = 3;

  logic        clk;
  logic        rst_n;
  logic        lb_wr_en;
  logic        lb_rd_en;
  logic [15:0] lb_addr;
  logic [31:0] lb_wr_data;
  logic        lb_wr_valid;
  logic        lb_rd_valid;
  logic [31:0] lb_rd_data;
  logic        pcm_valid;
  logic [15:0] pcm_sample;
  logic        sys_mem_wait;
  logic        sys_mem_wren;
  logic [26:0] sys_mem_addr;
  logic [31:0] sys_mem_wdata;

  // Test table, one entry per row
  string       name_t [NUM_TESTS];
  int          kind_t [NUM_TESTS];
  logic [15:0] addr_t [NUM_TESTS];
  logic [31:0] wdata_t [NUM_TESTS];
  logic [255:0] smp_t [NUM_TESTS];
  logic [31:0] exp_t [NUM_TESTS];
  int          rows = 0;

  // Memory model state
  logic [31:0] addr_q [$];
  logic [31:0] data_q [$];
  integer      seed = 32'h9bdba809;
  logic [31:0] draw;
  logic        use_bp;
  logic        bp_en = 1'b0;

  int err_cnt = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  int frames_done = 0;
  int cycles = 0;

  cortex UUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Write recorder, memory takes a word when not stalled
  always @(posedge clk) begin
    if (sys_mem_wren && !sys_mem_wait) begin
      addr_q.push_back(32'(sys_mem_addr));
      data_q.push_back(sys_mem_wdata);
    end
  end

  // Random stall only in back-pressure rows
  always @(posedge clk) begin
    draw = $random(seed);
    use_bp = bp_en;
    #5;
    sys_mem_wait = use_bp && draw[0];
  end

  // Watchdog
  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the run did not finish", MAX_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  function automatic logic [15:0] lb_at(input int blk, input logic [11:0] offs);
    return {4'(blk), offs};
  endfunction

  // Checker and assertion failures together
  function automatic int total_errors();
    return err_cnt + UUT.props_inst.assert_fails;
  endfunction

  task automatic add_test(input string name, input int kind, input logic [15:0] addr,
                          input logic [31:0] wdata, input logic [255:0] smp,
                          input logic [31:0] exp);
    name_t[rows] = name;
    kind_t[rows] = kind;
    addr_t[rows] = addr;
    wdata_t[rows] = wdata;
    smp_t[rows] = smp;
    exp_t[rows] = exp;
    rows++;
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("Fail %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Sum of magnitudes and largest magnitude over 16 signed samples
  task automatic expected_energy(input logic [255:0] smp, output logic [31:0] sum,
                                 output logic [31:0] peak);
    int v;
    int total;
    int top;
    total = 0;
    top = 0;
    for (int i = 0; i < 16; i++) begin
      v = int'($signed(smp[i*16 +: 16]));
      if (v < 0) v = -v;
      total += v;
      if (v > top) top = v;
    end
    sum = 32'(total);
    peak = 32'(top);
  endtask

  // One bus access plus an idle cycle, answer expected one cycle after the strobe
  task automatic bus_access(input bit wr, input logic [15:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    if (lb_wr_valid || lb_rd_valid) begin
      err_cnt++;
      $display("Bus valid was already high before the strobe to address %h", addr);
    end
    lb_wr_en = wr;
    lb_rd_en = !wr;
    lb_addr = addr;
    lb_wr_data = wdata;
    @(posedge clk);
    #5;
    lb_wr_en = 1'b0;
    lb_rd_en = 1'b0;
    if ((wr && !lb_wr_valid) || (!wr && !lb_rd_valid)) begin
      err_cnt++;
      $display("No bus valid one cycle after the strobe to address %h", addr);
    end
    rdata = lb_rd_data;
    @(posedge clk);
    #5;
  endtask

  task automatic run_frame(input int t);
    logic [31:0] sum_e;
    logic [31:0] peak_e;
    logic [31:0] rd;
    int n_exp;
    expected_energy(smp_t[t], sum_e, peak_e);
    n_exp = addr_q.size() + 2;
    bp_en = (kind_t[t] == K_FRAME_BP);
    for (int i = 0; i < 16; i++) begin
      pcm_valid = 1'b1;
      pcm_sample = smp_t[t][i*16 +: 16];
      @(posedge clk);
      #5;
    end
    pcm_valid = 1'b0;
    // Frame ends when the peak word reaches memory
    while (addr_q.size() < n_exp) begin
      @(posedge clk);
      #5;
    end
    bp_en = 1'b0;
    check(name_t[t], MEM_BASE + 32'(2 * frames_done), addr_q[n_exp-2]);
    check(name_t[t], MEM_BASE + 32'(2 * frames_done + 1), addr_q[n_exp-1]);
    check(name_t[t], sum_e, data_q[n_exp-2]);
    check(name_t[t], peak_e, data_q[n_exp-1]);
    frames_done++;
    bus_access(1'b0, lb_at(cortex_lb_pkg::NRG_BLK, cortex_lb_pkg::NRG_SUM_REG), '0, rd);
    check(name_t[t], sum_e, rd);
    bus_access(1'b0, lb_at(cortex_lb_pkg::NRG_BLK, cortex_lb_pkg::NRG_PEAK_REG), '0, rd);
    check(name_t[t], peak_e, rd);
    // Row register after the frame
    bus_access(1'b0, addr_t[t], '0, rd);
    check(name_t[t], exp_t[t], rd);
  endtask

  initial begin
    logic [31:0] rd;
    int errs_before;
    rst_n = 1'b0;
    lb_wr_en = 1'b0;
    lb_rd_en = 1'b0;
    lb_addr = '0;
    lb_wr_data = '0;
    pcm_valid = 1'b0;
    pcm_sample = '0;
    sys_mem_wait = 1'b0;

    add_test("base_rw", K_WR_RD, lb_at(cortex_lb_pkg::SYS_MEM_BLK, cortex_lb_pkg::MEM_BASE_REG),
             MEM_BASE, '0, MEM_BASE);
    add_test("blk_unmapped", K_RD, lb_at(7, 12'h004), '0, '0, 32'hdeadbabe);
    add_test("offs_unmapped", K_RD, lb_at(cortex_lb_pkg::SYS_MEM_BLK, 12'h005), '0, '0,
             32'hdeadbabe);
    // Includes the most negative sample, 16'h8000
    add_test("frame_one", K_FRAME, lb_at(cortex_lb_pkg::PCM_BLK, cortex_lb_pkg::PCM_FRAMES_REG),
             '0, 256'h8000_7fff_fff0_0010_0001_ffff_1234_edcc_0000_0100_ff00_0abc_f544_0002_fffe_0003,
             32'd1);
    add_test("frame_two", K_FRAME,
             lb_at(cortex_lb_pkg::SYS_MEM_BLK, cortex_lb_pkg::MEM_WR_CNT_REG), '0,
             256'h0100_ff00_0200_fe00_0300_fd00_0400_fc00_0500_fb00_0600_fa00_0700_f900_0800_f800,
             32'd4);
    add_test("frame_count", K_RD, lb_at(cortex_lb_pkg::PCM_BLK, cortex_lb_pkg::PCM_FRAMES_REG),
             '0, '0, 32'd2);
    add_test("frame_stall", K_FRAME_BP,
             lb_at(cortex_lb_pkg::SYS_MEM_BLK, cortex_lb_pkg::MEM_WR_CNT_REG), '0,
             256'h4000_c000_3fff_c001_0005_fffb_00aa_ff56_1357_eca9_0f0f_f0f1_7777_8889_0042_ffbe,
             32'd6);
    // Engine held in soft reset, then released
    add_test("nrg_rst_low", K_WR_RD, lb_at(cortex_lb_pkg::RST_BLK, cortex_lb_pkg::RST_VEC_REG),
             32'h5, '0, 32'h5);
    add_test("nrg_rst_high", K_WR_RD, lb_at(cortex_lb_pkg::RST_BLK, cortex_lb_pkg::RST_VEC_REG),
             32'h7, '0, 32'h7);
    add_test("sum_cleared", K_RD, lb_at(cortex_lb_pkg::NRG_BLK, cortex_lb_pkg::NRG_SUM_REG), '0,
             '0, 32'h0);
    add_test("base_kept", K_RD, lb_at(cortex_lb_pkg::SYS_MEM_BLK, cortex_lb_pkg::MEM_BASE_REG),
             '0, '0, MEM_BASE);

    repeat (RST_CYCLES) @(posedge clk);
    #5;
    rst_n = 1'b1;
    @(posedge clk);
    #5;

    for (int t = 0; t < NUM_TESTS; t++) begin
      errs_before = total_errors();
      case (kind_t[t])
        K_WR_RD: begin
          bus_access(1'b1, addr_t[t], wdata_t[t], rd);
          bus_access(1'b0, addr_t[t], '0, rd);
          check(name_t[t], exp_t[t], rd);
        end
        K_RD: begin
          bus_access(1'b0, addr_t[t], '0, rd);
          check(name_t[t], exp_t[t], rd);
        end
        default: run_frame(t);
      endcase
      if (total_errors() == errs_before) begin
        pass_cnt++;
        $display("Test %s ok", name_t[t]);
      end else begin
        fail_cnt++;
        $display("Test %s failed", name_t[t]);
      end
    end

    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (total_errors() == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* source/cortex.sv */
module cortex (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        lb_wr_en,
  input  logic                                        lb_rd_en,
  input  logic [cortex_lb_pkg::LB_ADDR_W-1:0]         lb_addr,
  input  logic [cortex_lb_pkg::LB_DATA_W-1:0]         lb_wr_data,
  output logic                                        lb_wr_valid,
  output logic                                        lb_rd_valid,
  output logic [cortex_lb_pkg::LB_DATA_W-1:0]         lb_rd_data,
  input  logic                                        pcm_valid,
  input  logic [cortex_audio_pkg::PCM_SAMPLE_W-1:0]   pcm_sample,
  input  logic                                        sys_mem_wait,
  output logic                                        sys_mem_wren,
  output logic [cortex_audio_pkg::SYS_MEM_ADDR_W-1:0] sys_mem_addr,
  output logic [cortex_audio_pkg::SYS_MEM_DATA_W-1:0] sys_mem_wdata
);

  // Splitter to child bus
  logic [cortex_lb_pkg::NUM_LB_CHILDREN-1:0]  chld_wr_en;
  logic [cortex_lb_pkg::NUM_LB_CHILDREN-1:0]  chld_rd_en;
  logic [cortex_lb_pkg::LB_CHLD_ADDR_W-1:0]   chld_addr;
  logic [cortex_lb_pkg::LB_DATA_W-1:0]        chld_wr_data;
  logic [cortex_lb_pkg::NUM_LB_CHILDREN-1:0]  chld_wr_valid;
  logic [cortex_lb_pkg::NUM_LB_CHILDREN-1:0]  chld_rd_valid;
  logic [cortex_lb_pkg::NUM_LB_CHILDREN-1:0][cortex_lb_pkg::LB_DATA_W-1:0] chld_rd_data;
  logic [cortex_lb_pkg::NUM_SOFT_RESETS-1:0]  soft_rst_n;

  // Buffer to engine
  logic                                        pcm_rdy;
  logic                                        pcm_rden;
  logic [cortex_audio_pkg::PCM_MEM_ADDR_W-1:0] pcm_addr;
  logic                                        pcm_rd_valid;
  logic [cortex_audio_pkg::PCM_SAMPLE_W-1:0]   pcm_rdata;
  logic                                        nrg_busy;

  // Engine to memory writer
  logic                                        agent_wren;
  logic                                        agent_offs;
  logic [cortex_audio_pkg::NRG_W-1:0]          agent_wdata;
  logic                                        agent_last;
  logic                                        agent_wait;

  // Host bus and child bus share port names
  lb_splitter lb_splitter_inst (.*);

  rst_cntrl rst_cntrl_inst (
    .lb_wr_en    (chld_wr_en[cortex_lb_pkg::RST_BLK]),
    .lb_rd_en    (chld_rd_en[cortex_lb_pkg::RST_BLK]),
    .lb_addr     (chld_addr),
    .lb_wr_data  (chld_wr_data),
    .lb_wr_valid (chld_wr_valid[cortex_lb_pkg::RST_BLK]),
    .lb_rd_valid (chld_rd_valid[cortex_lb_pkg::RST_BLK]),
    .lb_rd_data  (chld_rd_data[cortex_lb_pkg::RST_BLK]),
    .*
  );

  // Soft reset ANDed with the chip reset per block
  pcm_buffer pcm_buffer_inst (
    .rst_n       (rst_n && soft_rst_n[cortex_lb_pkg::PCM_RST_BIT]),
    .lb_wr_en    (chld_wr_en[cortex_lb_pkg::PCM_BLK]),
    .lb_rd_en    (chld_rd_en[cortex_lb_pkg::PCM_BLK]),
    .lb_addr     (chld_addr),
    .lb_wr_data  (chld_wr_data),
    .lb_wr_valid (chld_wr_valid[cortex_lb_pkg::PCM_BLK]),
    .lb_rd_valid (chld_rd_valid[cortex_lb_pkg::PCM_BLK]),
    .lb_rd_data  (chld_rd_data[cortex_lb_pkg::PCM_BLK]),
    .*
  );

  pcm_energy pcm_energy_inst (
    .rst_n       (rst_n && soft_rst_n[cortex_lb_pkg::NRG_RST_BIT]),
    .lb_wr_en    (chld_wr_en[cortex_lb_pkg::NRG_BLK]),
    .lb_rd_en    (chld_rd_en[cortex_lb_pkg::NRG_BLK]),
    .lb_addr     (chld_addr),
    .lb_wr_data  (chld_wr_data),
    .lb_wr_valid (chld_wr_valid[cortex_lb_pkg::NRG_BLK]),
    .lb_rd_valid (chld_rd_valid[cortex_lb_pkg::NRG_BLK]),
    .lb_rd_data  (chld_rd_data[cortex_lb_pkg::NRG_BLK]),
    .*
  );

  sys_mem_intf sys_mem_intf_inst (
    .rst_n       (rst_n && soft_rst_n[cortex_lb_pkg::MEM_RST_BIT]),
    .lb_wr_en    (chld_wr_en[cortex_lb_pkg::SYS_MEM_BLK]),
    .lb_rd_en    (chld_rd_en[cortex_lb_pkg::SYS_MEM_BLK]),
    .lb_addr     (chld_addr),
    .lb_wr_data  (chld_wr_data),
    .lb_wr_valid (chld_wr_valid[cortex_lb_pkg::SYS_MEM_BLK]),
    .lb_rd_valid (chld_rd_valid[cortex_lb_pkg::SYS_MEM_BLK]),
    .lb_rd_data  (chld_rd_data[cortex_lb_pkg::SYS_MEM_BLK]),
    .*
  );

endmodule

/* source/cortex_audio_pkg.sv */
package cortex_audio_pkg;

  // Signed two's complement PCM samples
  localparam int PCM_SAMPLE_W = 16;
  // Samples per frame, one bank
  localparam int NUM_AUD_SAMPLES = 16;
  // Bank bit plus sample index
  localparam int PCM_MEM_ADDR_W = 5;

  // Width of sum and peak results
  localparam int NRG_W = 32;

  // External memory side
  localparam int SYS_MEM_DATA_W = 32;
  localparam int SYS_MEM_ADDR_W = 27;
  // Sum word then peak word
  localparam logic [SYS_MEM_ADDR_W-1:0] WORDS_PER_FRAME = 27'd2;

endpackage

/* source/cortex_lb_pkg.sv */
package cortex_lb_pkg;

  // Local bus geometry
  localparam int LB_DATA_W = 32;
  localparam int LB_ADDR_W = 16;
  // Block id field, top address bits
  localparam int LB_BLK_W = 4;
  localparam int LB_CHLD_ADDR_W = 12;

  // Child block ids
  localparam int RST_BLK = 0;
  localparam int PCM_BLK = 1;
  localparam int NRG_BLK = 2;
  localparam int SYS_MEM_BLK = 3;
  localparam int NUM_LB_CHILDREN = 4;

  // Answer for unmapped blocks and offsets
  localparam logic [LB_DATA_W-1:0] DEFAULT_DATA_VAL = 32'hdeadbabe;

  // Register offsets inside each child
  localparam logic [LB_CHLD_ADDR_W-1:0] RST_VEC_REG = 12'd0;
  localparam logic [LB_CHLD_ADDR_W-1:0] PCM_OVERRUN_REG = 12'd0;
  localparam logic [LB_CHLD_ADDR_W-1:0] PCM_FRAMES_REG = 12'd1;
  localparam logic [LB_CHLD_ADDR_W-1:0] NRG_SUM_REG = 12'd0;
  localparam logic [LB_CHLD_ADDR_W-1:0] NRG_PEAK_REG = 12'd1;
  localparam logic [LB_CHLD_ADDR_W-1:0] MEM_BASE_REG = 12'd0;
  localparam logic [LB_CHLD_ADDR_W-1:0] MEM_WR_CNT_REG = 12'd1;

  // Soft reset vector layout
  localparam int NUM_SOFT_RESETS = 3;
  localparam int PCM_RST_BIT = 0;
  localparam int NRG_RST_BIT = 1;
  localparam int MEM_RST_BIT = 2;

endpackage

/* source/lb_splitter.sv */
module lb_splitter (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       lb_wr_en,
  input  logic                                       lb_rd_en,
  input  logic [cortex_lb_pkg::LB_ADDR_W-1:0]        lb_addr,
  input  logic [cortex_lb_pkg::LB_DATA_W-1:0]        lb_wr_data,
  output logic                                       lb_wr_valid,
  output logic                                       lb_rd_valid,
  output logic [cortex_lb_pkg::LB_DATA_W-1:0]        lb_rd_data,
  output logic [cortex_lb_pkg::NUM_LB_CHILDREN-1:0]  chld_wr_en,
  output logic [cortex_lb_pkg::NUM_LB_CHILDREN-1:0]  chld_rd_en,
  output logic [cortex_lb_pkg::LB_CHLD_ADDR_W-1:0]   chld_addr,
  output logic [cortex_lb_pkg::LB_DATA_W-1:0]        chld_wr_data,
  input  logic [cortex_lb_pkg::NUM_LB_CHILDREN-1:0]  chld_wr_valid,
  input  logic [cortex_lb_pkg::NUM_LB_CHILDREN-1:0]  chld_rd_valid,
  input  logic [cortex_lb_pkg::NUM_LB_CHILDREN-1:0][cortex_lb_pkg::LB_DATA_W-1:0] chld_rd_data
);

  logic [cortex_lb_pkg::LB_BLK_W-1:0]                 blk;
  logic                                               mapped;
  logic [$clog2(cortex_lb_pkg::NUM_LB_CHILDREN)-1:0]  sel_q;
  logic                                               unmapped_q;
  logic                                               dflt_wr_q;
  logic                                               dflt_rd_q;

  // Block id from the top address bits
  assign blk = lb_addr[cortex_lb_pkg::LB_ADDR_W-1 -: cortex_lb_pkg::LB_BLK_W];
  assign mapped = (blk < cortex_lb_pkg::NUM_LB_CHILDREN);

  // Address and data shared by all children
  assign chld_addr = lb_addr[cortex_lb_pkg::LB_CHLD_ADDR_W-1:0];
  assign chld_wr_data = lb_wr_data;

  // Strobe only the addressed child, same cycle
  always_comb begin
    for (int i = 0; i < cortex_lb_pkg::NUM_LB_CHILDREN; i++) begin
      chld_wr_en[i] = lb_wr_en && (blk == i);
      chld_rd_en[i] = lb_rd_en && (blk == i);
    end
  end

  // Remember target for the answer cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q <= '0;
      unmapped_q <= 1'b0;
      dflt_wr_q <= 1'b0;
      dflt_rd_q <= 1'b0;
    end else begin
      // Unmapped ids answered here
      dflt_wr_q <= lb_wr_en && !mapped;
      dflt_rd_q <= lb_rd_en && !mapped;
      if (lb_wr_en || lb_rd_en) begin
        sel_q <= blk[$bits(sel_q)-1:0];
        unmapped_q <= !mapped;
      end
    end
  end

  // Answer mux back to the host
  assign lb_wr_valid = dflt_wr_q || (!unmapped_q && chld_wr_valid[sel_q]);
  assign lb_rd_valid = dflt_rd_q || (!unmapped_q && chld_rd_valid[sel_q]);
  assign lb_rd_data = unmapped_q ? cortex_lb_pkg::DEFAULT_DATA_VAL : chld_rd_data[sel_q];

endmodule

/* source/pcm_buffer.sv */
module pcm_buffer (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        lb_wr_en,
  input  logic                                        lb_rd_en,
  input  logic [cortex_lb_pkg::LB_CHLD_ADDR_W-1:0]    lb_addr,
  input  logic [cortex_lb_pkg::LB_DATA_W-1:0]         lb_wr_data,
  output logic                                        lb_wr_valid,
  output logic                                        lb_rd_valid,
  output logic [cortex_lb_pkg::LB_DATA_W-1:0]         lb_rd_data,
  input  logic                                        pcm_valid,
  input  logic [cortex_audio_pkg::PCM_SAMPLE_W-1:0]   pcm_sample,
  output logic                                        pcm_rdy,
  input  logic                                        pcm_rden,
  input  logic [cortex_audio_pkg::PCM_MEM_ADDR_W-1:0] pcm_addr,
  output logic                                        pcm_rd_valid,
  output logic [cortex_audio_pkg::PCM_SAMPLE_W-1:0]   pcm_rdata,
  input  logic                                        nrg_busy
);

  // Two banks of one frame each
  logic [cortex_audio_pkg::PCM_SAMPLE_W-1:0]   mem [2*cortex_audio_pkg::NUM_AUD_SAMPLES];
  logic                                        fill_bank;
  logic [cortex_audio_pkg::PCM_MEM_ADDR_W-2:0] wr_idx;
  logic [cortex_lb_pkg::LB_DATA_W-1:0]         frame_cnt;
  logic [cortex_lb_pkg::LB_DATA_W-1:0]         ovr_cnt;

  // Sample store and engine read port
  always_ff @(posedge clk) begin
    if (pcm_valid) begin
      mem[{fill_bank, wr_idx}] <= pcm_sample;
    end
    pcm_rdata <= mem[pcm_addr];
  end

  // Fill pointer, bank flip on wrap
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_bank <= 1'b0;
      wr_idx <= '0;
      pcm_rdy <= 1'b0;
      pcm_rd_valid <= 1'b0;
    end else begin
      pcm_rdy <= 1'b0;
      pcm_rd_valid <= pcm_rden;
      if (pcm_valid) begin
        wr_idx <= wr_idx + 1'b1;
        if (wr_idx == cortex_audio_pkg::NUM_AUD_SAMPLES-1) begin
          fill_bank <= ~fill_bank;
          pcm_rdy <= 1'b1;
        end
      end
    end
  end

  // Frame and overrun counters, bus loadable
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_cnt <= '0;
      ovr_cnt <= '0;
      lb_wr_valid <= 1'b0;
      lb_rd_valid <= 1'b0;
    end else begin
      lb_wr_valid <= lb_wr_en;
      lb_rd_valid <= lb_rd_en;
      if (lb_wr_en && (lb_addr == cortex_lb_pkg::PCM_FRAMES_REG)) begin
        frame_cnt <= lb_wr_data;
      end else if (pcm_rdy) begin
        frame_cnt <= frame_cnt + 1'b1;
      end
      // Bank done while engine still busy
      if (lb_wr_en && (lb_addr == cortex_lb_pkg::PCM_OVERRUN_REG)) begin
        ovr_cnt <= lb_wr_data;
      end else if (pcm_rdy && nrg_busy) begin
        ovr_cnt <= ovr_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lb_rd_en) begin
      case (lb_addr)
        cortex_lb_pkg::PCM_OVERRUN_REG: lb_rd_data <= ovr_cnt;
        cortex_lb_pkg::PCM_FRAMES_REG:  lb_rd_data <= frame_cnt;
        default:                        lb_rd_data <= cortex_lb_pkg::DEFAULT_DATA_VAL;
      endcase
    end
  end

endmodule

/* source/pcm_energy.sv */
module pcm_energy (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        lb_wr_en,
  input  logic                                        lb_rd_en,
  input  logic [cortex_lb_pkg::LB_CHLD_ADDR_W-1:0]    lb_addr,
  input  logic [cortex_lb_pkg::LB_DATA_W-1:0]         lb_wr_data,
  output logic                                        lb_wr_valid,
  output logic                                        lb_rd_valid,
  output logic [cortex_lb_pkg::LB_DATA_W-1:0]         lb_rd_data,
  input  logic                                        pcm_rdy,
  output logic                                        pcm_rden,
  output logic [cortex_audio_pkg::PCM_MEM_ADDR_W-1:0] pcm_addr,
  input  logic                                        pcm_rd_valid,
  input  logic [cortex_audio_pkg::PCM_SAMPLE_W-1:0]   pcm_rdata,
  output logic                                        nrg_busy,
  output logic                                        agent_wren,
  output logic                                        agent_offs,
  output logic [cortex_audio_pkg::NRG_W-1:0]          agent_wdata,
  output logic                                        agent_last,
  input  logic                                        agent_wait
);

  typedef enum logic [2:0] {IDLE, RD, DRAIN, WR_SUM, WR_PEAK} nrg_st_t;

  nrg_st_t                                   state;
  logic                                      nxt_bank;
  logic [cortex_audio_pkg::PCM_SAMPLE_W-1:0] abs_smpl;
  logic [cortex_audio_pkg::NRG_W-1:0]        abs_ext;
  logic [cortex_audio_pkg::NRG_W-1:0]        sum_q;
  logic [cortex_audio_pkg::NRG_W-1:0]        peak_q;

  // Unsigned magnitude, -32768 gives 32768
  assign abs_smpl = pcm_rdata[cortex_audio_pkg::PCM_SAMPLE_W-1] ? (~pcm_rdata + 1'b1) : pcm_rdata;
  assign abs_ext = {{(cortex_audio_pkg::NRG_W-cortex_audio_pkg::PCM_SAMPLE_W){1'b0}}, abs_smpl};

  assign nrg_busy = (state != IDLE);
  // Sum at offset 0, peak at offset 1 and last
  assign agent_wren = (state == WR_SUM) || (state == WR_PEAK);
  assign agent_offs = (state == WR_PEAK);
  assign agent_last = (state == WR_PEAK);
  assign agent_wdata = (state == WR_PEAK) ? peak_q : sum_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      nxt_bank <= 1'b0;
      pcm_rden <= 1'b0;
      pcm_addr <= '0;
    end else begin
      // Tracks buffer bank, skipped frames too
      if (pcm_rdy) begin
        nxt_bank <= ~nxt_bank;
      end
      case (state)
        IDLE: begin
          if (pcm_rdy) begin
            pcm_rden <= 1'b1;
            pcm_addr <= {nxt_bank, {(cortex_audio_pkg::PCM_MEM_ADDR_W-1){1'b0}}};
            state <= RD;
          end
        end
        RD: begin
          if (pcm_addr[cortex_audio_pkg::PCM_MEM_ADDR_W-2:0] ==
              cortex_audio_pkg::NUM_AUD_SAMPLES-1) begin
            pcm_rden <= 1'b0;
            state <= DRAIN;
          end else begin
            pcm_addr <= pcm_addr + 1'b1;
          end
        end
        // Last sample lands this cycle
        DRAIN: state <= WR_SUM;
        WR_SUM: begin
          if (!agent_wait) begin
            state <= WR_PEAK;
          end
        end
        WR_PEAK: begin
          if (!agent_wait) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Accumulators double as result registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q <= '0;
      peak_q <= '0;
    end else if ((state == IDLE) && pcm_rdy) begin
      sum_q <= '0;
      peak_q <= '0;
    end else if (pcm_rd_valid) begin
      sum_q <= sum_q + abs_ext;
      if (abs_ext > peak_q) begin
        peak_q <= abs_ext;
      end
    end else if (lb_wr_en && (lb_addr == cortex_lb_pkg::NRG_SUM_REG)) begin
      sum_q <= lb_wr_data;
    end else if (lb_wr_en && (lb_addr == cortex_lb_pkg::NRG_PEAK_REG)) begin
      peak_q <= lb_wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lb_wr_valid <= 1'b0;
      lb_rd_valid <= 1'b0;
    end else begin
      lb_wr_valid <= lb_wr_en;
      lb_rd_valid <= lb_rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (lb_rd_en) begin
      case (lb_addr)
        cortex_lb_pkg::NRG_SUM_REG:  lb_rd_data <= sum_q;
        cortex_lb_pkg::NRG_PEAK_REG: lb_rd_data <= peak_q;
        default:                     lb_rd_data <= cortex_lb_pkg::DEFAULT_DATA_VAL;
      endcase
    end
  end

endmodule

/* source/rst_cntrl.sv */
module rst_cntrl (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       lb_wr_en,
  input  logic                                       lb_rd_en,
  input  logic [cortex_lb_pkg::LB_CHLD_ADDR_W-1:0]   lb_addr,
  input  logic [cortex_lb_pkg::LB_DATA_W-1:0]        lb_wr_data,
  output logic                                       lb_wr_valid,
  output logic                                       lb_rd_valid,
  output logic [cortex_lb_pkg::LB_DATA_W-1:0]        lb_rd_data,
  output logic [cortex_lb_pkg::NUM_SOFT_RESETS-1:0]  soft_rst_n
);

  // Reset vector register, all blocks running after rst_n
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      soft_rst_n <= '1;
      lb_wr_valid <= 1'b0;
      lb_rd_valid <= 1'b0;
    end else begin
      lb_wr_valid <= lb_wr_en;
      lb_rd_valid <= lb_rd_en;
      // Active low bit per block
      if (lb_wr_en && (lb_addr == cortex_lb_pkg::RST_VEC_REG)) begin
        soft_rst_n <= lb_wr_data[cortex_lb_pkg::NUM_SOFT_RESETS-1:0];
      end
    end
  end

  // Read back, one cycle after strobe
  always_ff @(posedge clk) begin
    if (lb_rd_en) begin
      if (lb_addr == cortex_lb_pkg::RST_VEC_REG) begin
        lb_rd_data <= {{(cortex_lb_pkg::LB_DATA_W-cortex_lb_pkg::NUM_SOFT_RESETS){1'b0}},
                       soft_rst_n};
      end else begin
        lb_rd_data <= cortex_lb_pkg::DEFAULT_DATA_VAL;
      end
    end
  end

endmodule

/* source/sys_mem_intf.sv */
module sys_mem_intf (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        lb_wr_en,
  input  logic                                        lb_rd_en,
  input  logic [cortex_lb_pkg::LB_CHLD_ADDR_W-1:0]    lb_addr,
  input  logic [cortex_lb_pkg::LB_DATA_W-1:0]         lb_wr_data,
  output logic                                        lb_wr_valid,
  output logic                                        lb_rd_valid,
  output logic [cortex_lb_pkg::LB_DATA_W-1:0]         lb_rd_data,
  input  logic                                        agent_wren,
  input  logic                                        agent_offs,
  input  logic [cortex_audio_pkg::NRG_W-1:0]          agent_wdata,
  input  logic                                        agent_last,
  output logic                                        agent_wait,
  input  logic                                        sys_mem_wait,
  output logic                                        sys_mem_wren,
  output logic [cortex_audio_pkg::SYS_MEM_ADDR_W-1:0] sys_mem_addr,
  output logic [cortex_audio_pkg::SYS_MEM_DATA_W-1:0] sys_mem_wdata
);

  logic [cortex_audio_pkg::SYS_MEM_ADDR_W-1:0] base_q;
  logic [cortex_audio_pkg::SYS_MEM_ADDR_W-1:0] frame_q;
  logic [cortex_lb_pkg::LB_DATA_W-1:0]         wr_cnt_q;
  logic                                        full_q;
  logic                                        accept;
  logic                                        done;

  // Hold register full means agent must wait
  assign agent_wait = full_q;
  assign sys_mem_wren = full_q;
  assign accept = agent_wren && !full_q;
  assign done = full_q && !sys_mem_wait;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
      frame_q <= '0;
      base_q <= '0;
      wr_cnt_q <= '0;
      lb_wr_valid <= 1'b0;
      lb_rd_valid <= 1'b0;
    end else begin
      lb_wr_valid <= lb_wr_en;
      lb_rd_valid <= lb_rd_en;
      if (accept) begin
        full_q <= 1'b1;
      end else if (done) begin
        full_q <= 1'b0;
      end
      // Next frame after the peak word
      if (accept && agent_last) begin
        frame_q <= frame_q + 1'b1;
      end
      if (lb_wr_en && (lb_addr == cortex_lb_pkg::MEM_BASE_REG)) begin
        base_q <= lb_wr_data[cortex_audio_pkg::SYS_MEM_ADDR_W-1:0];
      end
      if (lb_wr_en && (lb_addr == cortex_lb_pkg::MEM_WR_CNT_REG)) begin
        wr_cnt_q <= lb_wr_data;
      end else if (done) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
    end
  end

  // Payload held steady until memory takes it
  always_ff @(posedge clk) begin
    if (accept) begin
      sys_mem_addr <= base_q + frame_q * cortex_audio_pkg::WORDS_PER_FRAME + agent_offs;
      sys_mem_wdata <= agent_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (lb_rd_en) begin
      case (lb_addr)
        cortex_lb_pkg::MEM_BASE_REG: begin
          lb_rd_data <= {{(cortex_lb_pkg::LB_DATA_W-cortex_audio_pkg::SYS_MEM_ADDR_W){1'b0}},
                         base_q};
        end
        cortex_lb_pkg::MEM_WR_CNT_REG: lb_rd_data <= wr_cnt_q;
        default:                       lb_rd_data <= cortex_lb_pkg::DEFAULT_DATA_VAL;
      endcase
    end
  end

endmodule
